// ==== src/axi_router_cfg.svh ====
`ifndef AXI_ROUTER_CFG_SVH
`define AXI_ROUTER_CFG_SVH

// Bus widths
`define AXI_ID_W    4
`define AXI_ADDR_W  32
`define AXI_DATA_W  32
`define AXI_STRB_W  4
`define AXI_LEN_W   8

// Windows closed to master 2
`define FORBID_BASE_0  32'h0000_0000
`define FORBID_BASE_1  32'h0000_6000
`define FORBID_BASE_2  32'h0000_A000
`define FORBID_BASE_3  32'h0000_C000
`define FORBID_SIZE    32'd4096

`endif

// ==== src/axi_router_pkg.sv ====
`default_nettype none

`include "axi_router_cfg.svh"

package axi_router_pkg;

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_EXOKAY = 2'b01,
    RESP_SLVERR = 2'b10,
    RESP_DECERR = 2'b11
  } axi_resp_e;

  typedef enum logic [1:0] {
    BURST_FIXED = 2'b00,
    BURST_INCR  = 2'b01,
    BURST_WRAP  = 2'b10
  } axi_burst_e;

  typedef enum logic [1:0] {ST_WR_IDLE, ST_WR_DATA, ST_WR_RESP} wr_err_state_e;

  typedef enum logic {ST_RD_IDLE, ST_RD_DATA} rd_err_state_e;

  localparam logic [`AXI_ADDR_W-1:0] FORBID_BASES [4] =
    '{`FORBID_BASE_0, `FORBID_BASE_1, `FORBID_BASE_2, `FORBID_BASE_3};

  // Address below a base wraps to a large offset and misses that window
  function automatic logic is_forbidden(input logic [`AXI_ADDR_W-1:0] addr);
    logic hit;
    hit = 1'b0;
    for (int i = 0; i < 4; i++)
    begin
      if ((addr - FORBID_BASES[i]) < `FORBID_SIZE)
      begin
        hit = 1'b1;
      end
    end
    return hit;
  endfunction

endpackage

`default_nettype wire

// ==== src/axi_router_if.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "axi_router_cfg.svh"

interface error_wr_if;
  // Command
  logic                  cmd_valid;
  logic                  cmd_ready;
  logic [`AXI_ID_W-1:0]  cmd_id;
  logic [`AXI_LEN_W-1:0] cmd_len;
  // Write beats, data itself is dropped
  logic                  w_valid;
  logic                  w_ready;
  logic                  w_last;
  // Response
  logic                  b_valid;
  logic                  b_ready;
  logic [`AXI_ID_W-1:0]  b_id;

  modport guard (
    output cmd_valid, cmd_id, cmd_len, w_valid, w_last, b_ready,
    input  cmd_ready, w_ready, b_valid, b_id
  );

  modport slave (
    input  cmd_valid, cmd_id, cmd_len, w_valid, w_last, b_ready,
    output cmd_ready, w_ready, b_valid, b_id
  );
endinterface

interface error_rd_if;
  logic                  cmd_valid;
  logic                  cmd_ready;
  logic [`AXI_ID_W-1:0]  cmd_id;
  logic [`AXI_LEN_W-1:0] cmd_len;
  // Read beats, zero data added by the guard
  logic                  r_valid;
  logic                  r_ready;
  logic [`AXI_ID_W-1:0]  r_id;
  logic                  r_last;

  modport guard (
    output cmd_valid, cmd_id, cmd_len, r_ready,
    input  cmd_ready, r_valid, r_id, r_last
  );

  modport slave (
    input  cmd_valid, cmd_id, cmd_len, r_ready,
    output cmd_ready, r_valid, r_id, r_last
  );
endinterface

`default_nettype wire

// ==== src/wr_guard.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "axi_router_cfg.svh"

module wr_guard (
  input  wire                        axi_master_2_slave_router_clk,
  input  wire                        axi_master_2_slave_router_rstn,
  // Upstream master
  input  wire  [`AXI_ID_W-1:0]       awid,
  input  wire  [`AXI_ADDR_W-1:0]     awaddr,
  input  wire  [`AXI_LEN_W-1:0]      awlen,
  input  wire  [2:0]                 awsize,
  input  wire  [1:0]                 awburst,
  input  wire                        awvalid,
  output logic                       awready,
  input  wire  [`AXI_DATA_W-1:0]     wdata,
  input  wire  [`AXI_STRB_W-1:0]     wstrb,
  input  wire                        wlast,
  input  wire                        wvalid,
  output logic                       wready,
  output logic [`AXI_ID_W-1:0]       bid,
  output axi_router_pkg::axi_resp_e  bresp,
  output logic                       bvalid,
  input  wire                        bready,
  // Downstream interconnect
  output logic [`AXI_ID_W-1:0]       m2_awid,
  output logic [`AXI_ADDR_W-1:0]     m2_awaddr,
  output logic [`AXI_LEN_W-1:0]      m2_awlen,
  output logic [2:0]                 m2_awsize,
  output logic [1:0]                 m2_awburst,
  output logic                       m2_awvalid,
  input  wire                        m2_awready,
  output logic [`AXI_DATA_W-1:0]     m2_wdata,
  output logic [`AXI_STRB_W-1:0]     m2_wstrb,
  output logic                       m2_wlast,
  output logic                       m2_wvalid,
  input  wire                        m2_wready,
  input  wire  [`AXI_ID_W-1:0]       m2_bid,
  input  wire  [1:0]                 m2_bresp,
  input  wire                        m2_bvalid,
  output logic                       m2_bready,
  error_wr_if.guard                  err
);
  import axi_router_pkg::*;

  logic aw_forbidden;
  logic aw_open;
  logic aw_fire;
  logic w_last_fire;
  logic wr_busy;
  logic wr_route_err;

  //////////////////// AW
  assign aw_forbidden = is_forbidden(awaddr);
  assign aw_open      = !wr_busy;

  assign m2_awid    = awid;
  assign m2_awaddr  = awaddr;
  assign m2_awlen   = awlen;
  assign m2_awsize  = awsize;
  assign m2_awburst = awburst;
  assign m2_awvalid = awvalid && aw_open && !aw_forbidden;

  assign err.cmd_valid = awvalid && aw_open && aw_forbidden;
  assign err.cmd_id    = awid;
  assign err.cmd_len   = awlen;

  assign awready = aw_open && (aw_forbidden ? err.cmd_ready : m2_awready);
  assign aw_fire = awvalid && awready;

  // Route is held from AW acceptance up to the last W beat
  always_ff @(posedge axi_master_2_slave_router_clk or negedge axi_master_2_slave_router_rstn)
  begin
    if (!axi_master_2_slave_router_rstn)
    begin
      wr_busy      <= 1'b0;
      wr_route_err <= 1'b0;
    end
    else if (aw_fire)
    begin
      wr_busy      <= 1'b1;
      wr_route_err <= aw_forbidden;
    end
    else if (w_last_fire)
    begin
      wr_busy <= 1'b0;
    end
  end

  //////////////////// W
  assign m2_wdata  = wdata;
  assign m2_wstrb  = wstrb;
  assign m2_wlast  = wlast;
  assign m2_wvalid = wvalid && wr_busy && !wr_route_err;

  assign err.w_valid = wvalid && wr_busy && wr_route_err;
  assign err.w_last  = wlast;

  assign wready      = wr_busy && (wr_route_err ? err.w_ready : m2_wready);
  assign w_last_fire = wvalid && wready && wlast;

  //////////////////// B
  // Error response wins, downstream waits
  assign bvalid      = err.b_valid || m2_bvalid;
  assign bid         = err.b_valid ? err.b_id : m2_bid;
  assign bresp       = err.b_valid ? RESP_DECERR : axi_resp_e'(m2_bresp);
  assign err.b_ready = bready;
  assign m2_bready   = bready && !err.b_valid;

endmodule

`default_nettype wire

// ==== src/wr_decerr_slave.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "axi_router_cfg.svh"

module wr_decerr_slave (
  input  wire        axi_master_2_slave_router_clk,
  input  wire        axi_master_2_slave_router_rstn,
  error_wr_if.slave  err
);
  import axi_router_pkg::*;

  wr_err_state_e          state;
  wr_err_state_e          state_nxt;
  logic [`AXI_ID_W-1:0]   id_q;
  logic [`AXI_LEN_W-1:0]  len_q;
  logic [`AXI_LEN_W-1:0]  beat_cnt;
  logic                   cmd_fire;
  logic                   beat_fire;
  logic                   burst_done;

  assign cmd_fire   = err.cmd_valid && err.cmd_ready;
  assign beat_fire  = err.w_valid && err.w_ready;
  // Ends on wlast or once len+1 beats are in
  assign burst_done = err.w_last || (beat_cnt == len_q);

  always_comb
  begin
    state_nxt = state;
    case (state)
      ST_WR_IDLE:
      begin
        if (cmd_fire)
        begin
          state_nxt = ST_WR_DATA;
        end
      end
      ST_WR_DATA:
      begin
        if (beat_fire && burst_done)
        begin
          state_nxt = ST_WR_RESP;
        end
      end
      ST_WR_RESP:
      begin
        if (err.b_ready)
        begin
          state_nxt = ST_WR_IDLE;
        end
      end
      default:
      begin
        state_nxt = ST_WR_IDLE;
      end
    endcase
  end

  always_ff @(posedge axi_master_2_slave_router_clk or negedge axi_master_2_slave_router_rstn)
  begin
    if (!axi_master_2_slave_router_rstn)
    begin
      state         <= ST_WR_IDLE;
      err.cmd_ready <= 1'b0;
      beat_cnt      <= '0;
    end
    else
    begin
      state         <= state_nxt;
      err.cmd_ready <= (state_nxt == ST_WR_IDLE);
      if (cmd_fire)
      begin
        beat_cnt <= '0;
      end
      else if (beat_fire)
      begin
        beat_cnt <= beat_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge axi_master_2_slave_router_clk)
  begin
    if (cmd_fire)
    begin
      id_q  <= err.cmd_id;
      len_q <= err.cmd_len;
    end
  end

  assign err.w_ready = (state == ST_WR_DATA);
  assign err.b_valid = (state == ST_WR_RESP);
  assign err.b_id    = id_q;

endmodule

`default_nettype wire

// ==== src/rd_guard.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "axi_router_cfg.svh"

module rd_guard (
  input  wire                        axi_master_2_slave_router_clk,
  input  wire                        axi_master_2_slave_router_rstn,
  // Upstream master
  input  wire  [`AXI_ID_W-1:0]       arid,
  input  wire  [`AXI_ADDR_W-1:0]     araddr,
  input  wire  [`AXI_LEN_W-1:0]      arlen,
  input  wire  [2:0]                 arsize,
  input  wire  [1:0]                 arburst,
  input  wire                        arvalid,
  output logic                       arready,
  output logic [`AXI_ID_W-1:0]       rid,
  output logic [`AXI_DATA_W-1:0]     rdata,
  output axi_router_pkg::axi_resp_e  rresp,
  output logic                       rlast,
  output logic                       rvalid,
  input  wire                        rready,
  // Downstream interconnect
  output logic [`AXI_ID_W-1:0]       m2_arid,
  output logic [`AXI_ADDR_W-1:0]     m2_araddr,
  output logic [`AXI_LEN_W-1:0]      m2_arlen,
  output logic [2:0]                 m2_arsize,
  output logic [1:0]                 m2_arburst,
  output logic                       m2_arvalid,
  input  wire                        m2_arready,
  input  wire  [`AXI_ID_W-1:0]       m2_rid,
  input  wire  [`AXI_DATA_W-1:0]     m2_rdata,
  input  wire  [1:0]                 m2_rresp,
  input  wire                        m2_rlast,
  input  wire                        m2_rvalid,
  output logic                       m2_rready,
  error_rd_if.guard                  err
);
  import axi_router_pkg::*;

  logic ar_forbidden;
  logic err_sel;
  logic m2_r_keep;
  logic m2_r_fire;

  //////////////////// AR
  assign ar_forbidden = is_forbidden(araddr);

  assign m2_arid    = arid;
  assign m2_araddr  = araddr;
  assign m2_arlen   = arlen;
  assign m2_arsize  = arsize;
  assign m2_arburst = arburst;
  assign m2_arvalid = arvalid && !ar_forbidden;

  assign err.cmd_valid = arvalid && ar_forbidden;
  assign err.cmd_id    = arid;
  assign err.cmd_len   = arlen;

  assign arready = ar_forbidden ? err.cmd_ready : m2_arready;

  //////////////////// R
  // Downstream keeps R while a beat is on offer or its burst is open
  always_ff @(posedge axi_master_2_slave_router_clk or negedge axi_master_2_slave_router_rstn)
  begin
    if (!axi_master_2_slave_router_rstn)
    begin
      m2_r_keep <= 1'b0;
    end
    else if (m2_r_fire)
    begin
      m2_r_keep <= !m2_rlast;
    end
    else if (m2_rvalid && !err_sel)
    begin
      m2_r_keep <= 1'b1;
    end
  end

  assign err_sel   = err.r_valid && !m2_r_keep;
  assign m2_r_fire = m2_rvalid && m2_rready;

  assign rvalid      = err_sel || m2_rvalid;
  assign rid         = err_sel ? err.r_id : m2_rid;
  assign rdata       = err_sel ? '0 : m2_rdata;
  assign rresp       = err_sel ? RESP_DECERR : axi_resp_e'(m2_rresp);
  assign rlast       = err_sel ? err.r_last : m2_rlast;
  assign err.r_ready = rready && err_sel;
  assign m2_rready   = rready && !err_sel;

endmodule

`default_nettype wire

// ==== src/rd_decerr_slave.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "axi_router_cfg.svh"

module rd_decerr_slave (
  input  wire        axi_master_2_slave_router_clk,
  input  wire        axi_master_2_slave_router_rstn,
  error_rd_if.slave  err
);
  import axi_router_pkg::*;

  rd_err_state_e          state;
  rd_err_state_e          state_nxt;
  logic [`AXI_ID_W-1:0]   id_q;
  logic [`AXI_LEN_W-1:0]  len_q;
  logic [`AXI_LEN_W-1:0]  beat_cnt;
  logic                   cmd_fire;
  logic                   beat_fire;

  assign cmd_fire  = err.cmd_valid && err.cmd_ready;
  assign beat_fire = err.r_valid && err.r_ready;

  always_comb
  begin
    state_nxt = state;
    case (state)
      ST_RD_IDLE:
      begin
        if (cmd_fire)
        begin
          state_nxt = ST_RD_DATA;
        end
      end
      ST_RD_DATA:
      begin
        if (beat_fire && err.r_last)
        begin
          state_nxt = ST_RD_IDLE;
        end
      end
      default:
      begin
        state_nxt = ST_RD_IDLE;
      end
    endcase
  end

  always_ff @(posedge axi_master_2_slave_router_clk or negedge axi_master_2_slave_router_rstn)
  begin
    if (!axi_master_2_slave_router_rstn)
    begin
      state         <= ST_RD_IDLE;
      err.cmd_ready <= 1'b0;
      beat_cnt      <= '0;
    end
    else
    begin
      state         <= state_nxt;
      // One error read in flight at a time
      err.cmd_ready <= (state_nxt == ST_RD_IDLE);
      if (cmd_fire)
      begin
        beat_cnt <= '0;
      end
      else if (beat_fire)
      begin
        beat_cnt <= beat_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge axi_master_2_slave_router_clk)
  begin
    if (cmd_fire)
    begin
      id_q  <= err.cmd_id;
      len_q <= err.cmd_len;
    end
  end

  assign err.r_valid = (state == ST_RD_DATA);
  assign err.r_last  = (beat_cnt == len_q);
  assign err.r_id    = id_q;

endmodule

`default_nettype wire

// ==== src/axi_master_2_slave_router.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "axi_router_cfg.svh"

module axi_master_2_slave_router (
  input  wire                     axi_master_2_slave_router_clk,
  input  wire                     axi_master_2_slave_router_rstn,
  // Master 2 side
  input  wire  [`AXI_ID_W-1:0]    awid,
  input  wire  [`AXI_ADDR_W-1:0]  awaddr,
  input  wire  [`AXI_LEN_W-1:0]   awlen,
  input  wire  [2:0]              awsize,
  input  wire  [1:0]              awburst,
  input  wire                     awvalid,
  output logic                    awready,
  input  wire  [`AXI_DATA_W-1:0]  wdata,
  input  wire  [`AXI_STRB_W-1:0]  wstrb,
  input  wire                     wlast,
  input  wire                     wvalid,
  output logic                    wready,
  output logic [`AXI_ID_W-1:0]    bid,
  output logic [1:0]              bresp,
  output logic                    bvalid,
  input  wire                     bready,
  input  wire  [`AXI_ID_W-1:0]    arid,
  input  wire  [`AXI_ADDR_W-1:0]  araddr,
  input  wire  [`AXI_LEN_W-1:0]   arlen,
  input  wire  [2:0]              arsize,
  input  wire  [1:0]              arburst,
  input  wire                     arvalid,
  output logic                    arready,
  output logic [`AXI_ID_W-1:0]    rid,
  output logic [`AXI_DATA_W-1:0]  rdata,
  output logic [1:0]              rresp,
  output logic                    rlast,
  output logic                    rvalid,
  input  wire                     rready,
  // Interconnect side
  output logic [`AXI_ID_W-1:0]    m2_awid,
  output logic [`AXI_ADDR_W-1:0]  m2_awaddr,
  output logic [`AXI_LEN_W-1:0]   m2_awlen,
  output logic [2:0]              m2_awsize,
  output logic [1:0]              m2_awburst,
  output logic                    m2_awvalid,
  input  wire                     m2_awready,
  output logic [`AXI_DATA_W-1:0]  m2_wdata,
  output logic [`AXI_STRB_W-1:0]  m2_wstrb,
  output logic                    m2_wlast,
  output logic                    m2_wvalid,
  input  wire                     m2_wready,
  input  wire  [`AXI_ID_W-1:0]    m2_bid,
  input  wire  [1:0]              m2_bresp,
  input  wire                     m2_bvalid,
  output logic                    m2_bready,
  output logic [`AXI_ID_W-1:0]    m2_arid,
  output logic [`AXI_ADDR_W-1:0]  m2_araddr,
  output logic [`AXI_LEN_W-1:0]   m2_arlen,
  output logic [2:0]              m2_arsize,
  output logic [1:0]              m2_arburst,
  output logic                    m2_arvalid,
  input  wire                     m2_arready,
  input  wire  [`AXI_ID_W-1:0]    m2_rid,
  input  wire  [`AXI_DATA_W-1:0]  m2_rdata,
  input  wire  [1:0]              m2_rresp,
  input  wire                     m2_rlast,
  input  wire                     m2_rvalid,
  output logic                    m2_rready
);

  error_wr_if wr_err_if ();
  error_rd_if rd_err_if ();

  //////////////////// Write path
  wr_guard wr_guard_inst (.err(wr_err_if), .*);

  wr_decerr_slave wr_decerr_slave_inst (
    .axi_master_2_slave_router_clk  (axi_master_2_slave_router_clk),
    .axi_master_2_slave_router_rstn (axi_master_2_slave_router_rstn),
    .err                            (wr_err_if)
  );

  //////////////////// Read path
  rd_guard rd_guard_inst (.err(rd_err_if), .*);

  rd_decerr_slave rd_decerr_slave_inst (
    .axi_master_2_slave_router_clk  (axi_master_2_slave_router_clk),
    .axi_master_2_slave_router_rstn (axi_master_2_slave_router_rstn),
    .err                            (rd_err_if)
  );

endmodule

`default_nettype wire

// ==== dv/tb_clk_gen.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_clk_gen (
  output logic clk,
  output logic rstn
);
  localparam time HALF_PERIOD = 20ns;
  localparam int  RESET_CYCLES = 5;

  initial
  begin
    clk = 1'b0;
    forever
    begin
      #(HALF_PERIOD);
      clk = ~clk;
    end
  end

  // Release lands just after an edge, clear of the sampling point
  initial
  begin
    rstn = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #2;
    rstn = 1'b1;
  end

endmodule

`default_nettype wire

// ==== dv/axi_router_props.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "axi_router_cfg.svh"

module axi_router_props (
  input wire                    axi_master_2_slave_router_clk,
  input wire                    axi_master_2_slave_router_rstn,
  input wire                    m2_awvalid,
  input wire                    m2_awready,
  input wire [`AXI_ID_W-1:0]    m2_awid,
  input wire [`AXI_ADDR_W-1:0]  m2_awaddr,
  input wire [`AXI_LEN_W-1:0]   m2_awlen,
  input wire                    m2_arvalid,
  input wire [`AXI_ADDR_W-1:0]  m2_araddr,
  input wire                    bvalid,
  input wire                    bready,
  input wire [`AXI_ID_W-1:0]    bid,
  input wire [1:0]              bresp,
  input wire                    rvalid,
  input wire                    rready,
  input wire [`AXI_ID_W-1:0]    rid,
  input wire [`AXI_DATA_W-1:0]  rdata,
  input wire [1:0]              rresp,
  input wire                    rlast,
  input wire                    err_b_valid,
  input wire                    err_r_valid
);
  wire         clk;
  wire         rstn;
  int unsigned fail_count = 0;

  assign clk  = axi_master_2_slave_router_clk;
  assign rstn = axi_master_2_slave_router_rstn;

  // 4 KB page compare against the closed windows
  function automatic logic in_window(input logic [`AXI_ADDR_W-1:0] addr);
    logic [`AXI_ADDR_W-1:0] page;
    page = addr & ~(`FORBID_SIZE - 1);
    return (page == `FORBID_BASE_0) || (page == `FORBID_BASE_1) ||
           (page == `FORBID_BASE_2) || (page == `FORBID_BASE_3);
  endfunction

  //////////////////// Stability
  aw_hold: assert property (@(posedge clk) disable iff (!rstn)
    (m2_awvalid && !m2_awready) |=>
      (m2_awvalid && $stable({m2_awid, m2_awaddr, m2_awlen})))
    else
    begin
      fail_count++;
      $error("m2 AW payload dropped or changed while stalled");
    end

  b_hold: assert property (@(posedge clk) disable iff (!rstn)
    (bvalid && !bready) |=> (bvalid && $stable({bid, bresp})))
    else
    begin
      fail_count++;
      $error("B response dropped or changed while stalled");
    end

  r_hold: assert property (@(posedge clk) disable iff (!rstn)
    (rvalid && !rready) |=> (rvalid && $stable({rid, rdata, rresp, rlast})))
    else
    begin
      fail_count++;
      $error("R beat dropped or changed while stalled");
    end

  //////////////////// Reset and steering
  reset_idle: assert property (@(posedge clk)
    $rose(rstn) |-> (!err_b_valid && !err_r_valid))
    else
    begin
      fail_count++;
      $error("Error slave response valid right after reset");
    end

  aw_closed: assert property (@(posedge clk) disable iff (!rstn)
    m2_awvalid |-> !in_window(m2_awaddr))
    else
    begin
      fail_count++;
      $error("m2_awvalid raised for a closed window");
    end

  ar_closed: assert property (@(posedge clk) disable iff (!rstn)
    m2_arvalid |-> !in_window(m2_araddr))
    else
    begin
      fail_count++;
      $error("m2_arvalid raised for a closed window");
    end

endmodule

bind axi_master_2_slave_router axi_router_props axi_router_props_inst (
  .*,
  .err_b_valid (wr_err_if.b_valid),
  .err_r_valid (rd_err_if.r_valid)
);

`default_nettype wire

// ==== dv/axi_router_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "axi_router_cfg.svh"

module axi_router_tb;
  import axi_router_pkg::*;

  typedef enum logic {KIND_WR, KIND_RD} kind_e;

  typedef struct {
    kind_e                   kind;
    logic [`AXI_ID_W-1:0]    id;
    logic [`AXI_ADDR_W-1:0]  addr;
    logic [`AXI_LEN_W-1:0]   len;
    axi_resp_e               resp;
  } txn_t;

  localparam int NUM_TXN         = 15;
  localparam int CYCLES_PER_BEAT = 40;

  wire clk;
  wire rstn;

  logic [`AXI_ID_W-1:0]    awid, bid, arid, rid, m2_awid, m2_bid, m2_arid, m2_rid;
  logic [`AXI_ADDR_W-1:0]  awaddr, araddr, m2_awaddr, m2_araddr;
  logic [`AXI_LEN_W-1:0]   awlen, arlen, m2_awlen, m2_arlen;
  logic [2:0]              awsize, arsize, m2_awsize, m2_arsize;
  logic [1:0]              awburst, arburst, m2_awburst, m2_arburst;
  logic [`AXI_DATA_W-1:0]  wdata, rdata, m2_wdata, m2_rdata;
  logic [`AXI_STRB_W-1:0]  wstrb, m2_wstrb;
  logic [1:0]              bresp, rresp, m2_bresp, m2_rresp;
  logic                    awvalid, awready, wvalid, wready, wlast, bvalid, bready;
  logic                    arvalid, arready, rvalid, rready, rlast;
  logic                    m2_awvalid, m2_awready, m2_wvalid, m2_wready, m2_wlast;
  logic                    m2_bvalid, m2_bready, m2_arvalid, m2_arready;
  logic                    m2_rvalid, m2_rready, m2_rlast;

  txn_t tbl [NUM_TXN];
  int   cur;
  logic guard_on;
  int   m2_wr_bursts;
  int   m2_rd_bursts;
  int   cycle_limit;
  int   cycles = 0;

  tb_clk_gen clk_gen_inst (
    .clk  (clk),
    .rstn (rstn)
  );

  axi_master_2_slave_router axi_master_2_slave_router_inst (
    .axi_master_2_slave_router_clk  (clk),
    .axi_master_2_slave_router_rstn (rstn),
    .*
  );

  //////////////////// Reporting
  task automatic stop_run(input string line);
    $display("%s", line);
    $display(">>> FAIL");
    $fatal(1, "Run stopped at the first failure");
  endtask

  task automatic check_resp(input axi_resp_e actual, input axi_resp_e expected,
                            input string what);
    if (actual !== expected)
    begin
      stop_run($sformatf("[ERROR] %0d ns %s: got %s, expected %s",
                         $time, what, actual.name(), expected.name()));
    end
  endtask

  task automatic check_id(input logic [`AXI_ID_W-1:0] actual,
                          input logic [`AXI_ID_W-1:0] expected, input string what);
    if (actual !== expected)
    begin
      stop_run($sformatf("[ERROR] %0d ns %s: got %h, expected %h",
                         $time, what, actual, expected));
    end
  endtask

  task automatic check_data(input logic [`AXI_DATA_W-1:0] actual,
                            input logic [`AXI_DATA_W-1:0] expected, input string what);
    if (actual !== expected)
    begin
      stop_run($sformatf("[ERROR] %0d ns %s: got %h, expected %h",
                         $time, what, actual, expected));
    end
  endtask

  task automatic check_addr(input logic [`AXI_ADDR_W-1:0] actual,
                            input logic [`AXI_ADDR_W-1:0] expected, input string what);
    if (actual !== expected)
    begin
      stop_run($sformatf("[ERROR] %0d ns %s: got %h, expected %h",
                         $time, what, actual, expected));
    end
  endtask

  task automatic check_len(input logic [`AXI_LEN_W-1:0] actual,
                           input logic [`AXI_LEN_W-1:0] expected, input string what);
    if (actual !== expected)
    begin
      stop_run($sformatf("[ERROR] %0d ns %s: got %0d, expected %0d",
                         $time, what, actual, expected));
    end
  endtask

  task automatic check_flag(input logic actual, input logic expected, input string what);
    if (actual !== expected)
    begin
      stop_run($sformatf("[ERROR] %0d ns %s: got %b, expected %b",
                         $time, what, actual, expected));
    end
  endtask

  function automatic logic [`AXI_DATA_W-1:0] wr_beat_data(
    input logic [`AXI_ADDR_W-1:0] addr, input int beat);
    return (addr ^ 32'h5a5a_0000) + beat;
  endfunction

  //////////////////// Upstream master
  task automatic send_write(input txn_t t);
    logic fire;
    awid    = t.id;
    awaddr  = t.addr;
    awlen   = t.len;
    awsize  = 3'd2;
    awburst = BURST_INCR;
    awvalid = 1'b1;
    fire    = 1'b0;
    while (!fire)
    begin
      @(negedge clk);
      fire = awready;
      @(posedge clk);
      #2;
    end
    awvalid = 1'b0;
    for (int beat = 0; beat <= t.len; beat++)
    begin
      wdata  = wr_beat_data(t.addr, beat);
      wstrb  = '1;
      wlast  = (beat == t.len);
      wvalid = 1'b1;
      fire   = 1'b0;
      while (!fire)
      begin
        @(negedge clk);
        fire = wready;
        @(posedge clk);
        #2;
      end
    end
    wvalid = 1'b0;
    wlast  = 1'b0;
    fire   = 1'b0;
    while (!fire)
    begin
      @(negedge clk);
      fire = bvalid && bready;
    end
    check_id(bid, t.id, "bid");
    check_resp(axi_resp_e'(bresp), t.resp, "bresp");
    @(negedge clk);
    check_flag(bvalid, 1'b0, "bvalid after the response");
    @(posedge clk);
    #2;
  endtask

  task automatic send_read(input txn_t t);
    logic                   fire;
    logic [`AXI_DATA_W-1:0] exp_data;
    int                     beat;
    arid    = t.id;
    araddr  = t.addr;
    arlen   = t.len;
    arsize  = 3'd2;
    arburst = BURST_INCR;
    arvalid = 1'b1;
    fire    = 1'b0;
    while (!fire)
    begin
      @(negedge clk);
      fire = arready;
      @(posedge clk);
      #2;
    end
    arvalid = 1'b0;
    beat    = 0;
    while (beat <= t.len)
    begin
      @(negedge clk);
      if (rvalid && rready)
      begin
        // Refused reads carry zero data
        exp_data = (t.resp == RESP_OKAY) ? t.addr + beat : '0;
        check_id(rid, t.id, "rid");
        check_resp(axi_resp_e'(rresp), t.resp, "rresp");
        check_data(rdata, exp_data, "rdata");
        check_flag(rlast, beat == t.len, "rlast");
        beat++;
      end
    end
    @(negedge clk);
    check_flag(rvalid, 1'b0, "rvalid after the last beat");
    @(posedge clk);
    #2;
  endtask

  //////////////////// Downstream slave model
  initial
  begin : ready_gen
    m2_awready = 1'b0;
    m2_wready  = 1'b0;
    m2_arready = 1'b0;
    bready     = 1'b0;
    rready     = 1'b0;
    void'($urandom(32'ha519_0746));
    forever
    begin
      @(posedge clk);
      #2;
      m2_awready = ($urandom % 4) != 0;
      m2_wready  = ($urandom % 4) != 0;
      m2_arready = ($urandom % 4) != 0;
      bready     = ($urandom % 4) != 0;
      rready     = ($urandom % 4) != 0;
    end
  end

  initial
  begin : write_model
    logic [`AXI_ID_W-1:0]  id;
    logic [`AXI_LEN_W-1:0] len;
    logic                  fire;
    int                    beat;
    m2_bvalid    = 1'b0;
    m2_bid       = '0;
    m2_bresp     = '0;
    m2_wr_bursts = 0;
    forever
    begin
      @(negedge clk);
      if (rstn && m2_awvalid && m2_awready)
      begin
        check_id(m2_awid, tbl[cur].id, "m2_awid");
        check_addr(m2_awaddr, tbl[cur].addr, "m2_awaddr");
        check_len(m2_awlen, tbl[cur].len, "m2_awlen");
        check_flag(m2_awsize == 3'd2 && m2_awburst == BURST_INCR, 1'b1, "m2_awsize/awburst");
        m2_wr_bursts++;
        id   = m2_awid;
        len  = m2_awlen;
        beat = 0;
        while (beat <= len)
        begin
          @(negedge clk);
          if (m2_wvalid && m2_wready)
          begin
            check_data(m2_wdata, wr_beat_data(tbl[cur].addr, beat), "m2_wdata");
            check_flag(m2_wlast, beat == len, "m2_wlast");
            check_flag(m2_wstrb == '1, 1'b1, "m2_wstrb");
            beat++;
          end
        end
        @(posedge clk);
        #2;
        m2_bid    = id;
        m2_bresp  = RESP_OKAY;
        m2_bvalid = 1'b1;
        fire      = 1'b0;
        while (!fire)
        begin
          @(negedge clk);
          fire = m2_bready;
          @(posedge clk);
          #2;
        end
        m2_bvalid = 1'b0;
      end
    end
  end

  initial
  begin : read_model
    logic [`AXI_ID_W-1:0]   id;
    logic [`AXI_ADDR_W-1:0] addr;
    logic [`AXI_LEN_W-1:0]  len;
    logic                   fire;
    m2_rvalid    = 1'b0;
    m2_rid       = '0;
    m2_rdata     = '0;
    m2_rresp     = '0;
    m2_rlast     = 1'b0;
    m2_rd_bursts = 0;
    forever
    begin
      @(negedge clk);
      if (rstn && m2_arvalid && m2_arready)
      begin
        check_id(m2_arid, tbl[cur].id, "m2_arid");
        check_addr(m2_araddr, tbl[cur].addr, "m2_araddr");
        check_len(m2_arlen, tbl[cur].len, "m2_arlen");
        check_flag(m2_arsize == 3'd2 && m2_arburst == BURST_INCR, 1'b1, "m2_arsize/arburst");
        m2_rd_bursts++;
        id   = m2_arid;
        addr = m2_araddr;
        len  = m2_arlen;
        @(posedge clk);
        #2;
        for (int beat = 0; beat <= len; beat++)
        begin
          m2_rid    = id;
          m2_rdata  = addr + beat;
          m2_rresp  = RESP_OKAY;
          m2_rlast  = (beat == len);
          m2_rvalid = 1'b1;
          fire      = 1'b0;
          while (!fire)
          begin
            @(negedge clk);
            fire = m2_rready;
            @(posedge clk);
            #2;
          end
        end
        m2_rvalid = 1'b0;
        m2_rlast  = 1'b0;
      end
    end
  end

  //////////////////// Monitors
  always @(negedge clk)
  begin
    if (guard_on && (m2_awvalid || m2_wvalid || m2_arvalid))
    begin
      stop_run("A burst to a closed window showed up on the downstream port");
    end
    if (axi_master_2_slave_router_inst.axi_router_props_inst.fail_count != 0)
    begin
      stop_run("A bound property check failed, see the assertion message above");
    end
  end

  always @(posedge clk)
  begin
    cycles++;
    if (cycles >= cycle_limit)
    begin
      stop_run($sformatf("Timeout after %0d cycles, the table did not finish", cycles));
    end
  end

  //////////////////// Table
  initial
  begin : main
    int total_beats;
    int exp_wr;
    int exp_rd;
    awid     = '0;
    awaddr   = '0;
    awlen    = '0;
    awsize   = '0;
    awburst  = '0;
    awvalid  = 1'b0;
    wdata    = '0;
    wstrb    = '0;
    wlast    = 1'b0;
    wvalid   = 1'b0;
    arid     = '0;
    araddr   = '0;
    arlen    = '0;
    arsize   = '0;
    arburst  = '0;
    arvalid  = 1'b0;
    cur      = 0;
    guard_on = 1'b0;

    // Kind, id, address, len, expected response
    tbl[0]  = '{KIND_WR, 4'h1, 32'h0000_1000, 8'd3, RESP_OKAY};
    tbl[1]  = '{KIND_WR, 4'h2, 32'h0000_0010, 8'd1, RESP_DECERR};
    tbl[2]  = '{KIND_WR, 4'h3, 32'h0000_6000, 8'd2, RESP_DECERR};
    tbl[3]  = '{KIND_WR, 4'h4, 32'h0000_A7F0, 8'd0, RESP_DECERR};
    tbl[4]  = '{KIND_WR, 4'h5, 32'h0000_CFFC, 8'd3, RESP_DECERR};
    tbl[5]  = '{KIND_RD, 4'h6, 32'h0000_5FFF, 8'd3, RESP_OKAY};
    tbl[6]  = '{KIND_RD, 4'h7, 32'h0000_7000, 8'd2, RESP_OKAY};
    tbl[7]  = '{KIND_RD, 4'h8, 32'h0000_0FFC, 8'd2, RESP_DECERR};
    tbl[8]  = '{KIND_RD, 4'h9, 32'h0000_6FFF, 8'd0, RESP_DECERR};
    tbl[9]  = '{KIND_RD, 4'hA, 32'h0000_A000, 8'd4, RESP_DECERR};
    tbl[10] = '{KIND_RD, 4'hB, 32'h0000_C800, 8'd1, RESP_DECERR};
    tbl[11] = '{KIND_WR, 4'hC, 32'h0000_5FFF, 8'd2, RESP_OKAY};
    tbl[12] = '{KIND_WR, 4'hD, 32'h0000_7000, 8'd0, RESP_OKAY};
    tbl[13] = '{KIND_RD, 4'hE, 32'h2000_0000, 8'd7, RESP_OKAY};
    tbl[14] = '{KIND_WR, 4'hF, 32'h0000_B000, 8'd5, RESP_OKAY};

    total_beats = 0;
    foreach (tbl[i])
    begin
      total_beats += int'(tbl[i].len) + 1;
    end
    cycle_limit = CYCLES_PER_BEAT * total_beats;

    @(posedge rstn);
    @(posedge clk);
    #2;
    for (int i = 0; i < NUM_TXN; i++)
    begin
      cur      = i;
      guard_on = (tbl[i].resp == RESP_DECERR);
      exp_wr   = m2_wr_bursts + ((tbl[i].kind == KIND_WR && !guard_on) ? 1 : 0);
      exp_rd   = m2_rd_bursts + ((tbl[i].kind == KIND_RD && !guard_on) ? 1 : 0);
      if (tbl[i].kind == KIND_WR)
      begin
        send_write(tbl[i]);
      end
      else
      begin
        send_read(tbl[i]);
      end
      check_flag(m2_wr_bursts == exp_wr, 1'b1, "downstream write burst count");
      check_flag(m2_rd_bursts == exp_rd, 1'b1, "downstream read burst count");
    end
    guard_on = 1'b0;

    if (axi_master_2_slave_router_inst.axi_router_props_inst.fail_count == 0)
    begin
      $display(">>> PASS");
      $finish;
    end
    else
    begin
      stop_run("A bound property check failed during the run");
    end
  end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+src
src/axi_router_pkg.sv
src/axi_router_if.sv
src/wr_guard.sv
src/wr_decerr_slave.sv
src/rd_guard.sv
src/rd_decerr_slave.sv
src/axi_master_2_slave_router.sv
dv/tb_clk_gen.sv
dv/axi_router_props.sv
dv/axi_router_tb.sv
